/* design/expipe_pkg.sv */
package expipe_pkg;

  // ------------------------------------------------------------------------
  // datapath widths
  // ------------------------------------------------------------------------

  // integer register width
  localparam int unsigned XLEN = 32;

  // rob index width, up to 16 in flight
  localparam int unsigned ROB_IDX_LEN = 4;

  // producer tag on operands and on the cdb
  typedef logic [ROB_IDX_LEN-1:0] rob_idx_t;

  // ------------------------------------------------------------------------
  // execution unit control codes
  // ------------------------------------------------------------------------

  // alu operations
  // slt compares signed, shifts take rs2[4:0]
  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_XOR = 3'd4,
    ALU_SLL = 3'd5,
    ALU_SRL = 3'd6,
    ALU_SLT = 3'd7
  } alu_op_t;

  // multiplier operations, both unsigned
  typedef enum logic [0:0] {
    MULT_MUL   = 1'b0,
    MULT_MULHU = 1'b1
  } mult_op_t;

  // ------------------------------------------------------------------------
  // execution unit indices
  // ------------------------------------------------------------------------

  // position in the per-unit issue and grant vectors
  typedef enum logic [0:0] {
    EU_ALU  = 1'b0,
    EU_MULT = 1'b1
  } eu_sel_e;

  // number of units on the cdb
  localparam int unsigned EU_N = 2;

endpackage

/* design/reservation_station.sv */
`timescale 1ns/1ps

module reservation_station import expipe_pkg::*; #(
  parameter int unsigned DEPTH = 4,
  parameter type         CTL_T = alu_op_t
) (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic            flush_i,
  // issue side
  input  logic            issue_valid_i,
  output logic            issue_ready_o,
  input  CTL_T            issue_ctl_i,
  input  logic            issue_rs1_ready_i,
  input  rob_idx_t        issue_rs1_tag_i,
  input  logic [XLEN-1:0] issue_rs1_value_i,
  input  logic            issue_rs2_ready_i,
  input  rob_idx_t        issue_rs2_tag_i,
  input  logic [XLEN-1:0] issue_rs2_value_i,
  input  rob_idx_t        issue_rob_idx_i,
  // common data bus snoop
  input  logic            cdb_valid_i,
  input  rob_idx_t        cdb_rob_idx_i,
  input  logic [XLEN-1:0] cdb_value_i,
  // dispatch toward the execution logic
  output logic            exec_valid_o,
  input  logic            exec_ready_i,
  output CTL_T            exec_ctl_o,
  output logic [XLEN-1:0] exec_rs1_value_o,
  output logic [XLEN-1:0] exec_rs2_value_o,
  output rob_idx_t        exec_rob_idx_o
);

  localparam int unsigned IDX_W = $clog2(DEPTH);

  // entry state, operand slot 0 is rs1 and slot 1 is rs2
  logic [DEPTH-1:0] busy_q;
  CTL_T             ctl_q [DEPTH];
  rob_idx_t         dst_q [DEPTH];
  logic             rdy_q [DEPTH][2];
  rob_idx_t         tag_q [DEPTH][2];
  logic [XLEN-1:0]  val_q [DEPTH][2];

  // incoming operands as slots
  logic             in_rdy [2];
  rob_idx_t         in_tag [2];
  logic [XLEN-1:0]  in_val [2];

  logic [DEPTH-1:0] eligible;
  logic [IDX_W-1:0] free_idx;
  logic [IDX_W-1:0] exec_idx;
  logic             issue_fire;
  logic             exec_fire;

  assign in_rdy[0] = issue_rs1_ready_i;
  assign in_tag[0] = issue_rs1_tag_i;
  assign in_val[0] = issue_rs1_value_i;
  assign in_rdy[1] = issue_rs2_ready_i;
  assign in_tag[1] = issue_rs2_tag_i;
  assign in_val[1] = issue_rs2_value_i;

  // ------------------------------------------------------------------------
  // entry selection
  // ------------------------------------------------------------------------

  // lowest free entry, scanned downward so index 0 wins
  always_comb begin
    free_idx = '0;
    for (int i = DEPTH - 1; i >= 0; i--) begin
      if (!busy_q[i]) free_idx = IDX_W'(i);
    end
  end

  // both operands present
  always_comb begin
    for (int i = 0; i < DEPTH; i++) begin
      eligible[i] = busy_q[i] && rdy_q[i][0] && rdy_q[i][1];
    end
  end

  // lowest eligible entry, not the oldest
  always_comb begin
    exec_idx = '0;
    for (int i = DEPTH - 1; i >= 0; i--) begin
      if (eligible[i]) exec_idx = IDX_W'(i);
    end
  end

  assign issue_ready_o = ~&busy_q;
  assign issue_fire    = issue_valid_i && issue_ready_o && !flush_i;
  assign exec_valid_o  = |eligible;
  assign exec_fire     = exec_valid_o && exec_ready_i;

  assign exec_ctl_o       = ctl_q[exec_idx];
  assign exec_rs1_value_o = val_q[exec_idx][0];
  assign exec_rs2_value_o = val_q[exec_idx][1];
  assign exec_rob_idx_o   = dst_q[exec_idx];

  // ------------------------------------------------------------------------
  // occupancy
  // ------------------------------------------------------------------------

  always_ff @(posedge clk_i) begin
    if (!rst_n_i || flush_i) begin
      busy_q <= '0;
    end else begin
      // free and fill never hit the same entry
      if (exec_fire) busy_q[exec_idx] <= 1'b0;
      if (issue_fire) busy_q[free_idx] <= 1'b1;
    end
  end

  // ------------------------------------------------------------------------
  // payload and operand capture
  // ------------------------------------------------------------------------

  always_ff @(posedge clk_i) begin
    // waiting slots snoop the bus
    for (int i = 0; i < DEPTH; i++) begin
      for (int j = 0; j < 2; j++) begin
        if (cdb_valid_i && busy_q[i] && !rdy_q[i][j] && tag_q[i][j] == cdb_rob_idx_i) begin
          rdy_q[i][j] <= 1'b1;
          val_q[i][j] <= cdb_value_i;
        end
      end
    end
    // new entry, also catches a broadcast in the issue cycle
    if (issue_fire) begin
      ctl_q[free_idx] <= issue_ctl_i;
      dst_q[free_idx] <= issue_rob_idx_i;
      for (int j = 0; j < 2; j++) begin
        tag_q[free_idx][j] <= in_tag[j];
        if (in_rdy[j]) begin
          rdy_q[free_idx][j] <= 1'b1;
          val_q[free_idx][j] <= in_val[j];
        end else if (cdb_valid_i && cdb_rob_idx_i == in_tag[j]) begin
          rdy_q[free_idx][j] <= 1'b1;
          val_q[free_idx][j] <= cdb_value_i;
        end else begin
          rdy_q[free_idx][j] <= 1'b0;
        end
      end
    end
  end

endmodule

/* design/alu_unit.sv */
`timescale 1ns/1ps

module alu_unit import expipe_pkg::*; #(
  parameter int unsigned DEPTH = 4
) (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic            flush_i,
  // issue
  input  logic            issue_valid_i,
  output logic            issue_ready_o,
  input  logic [2:0]      issue_op_i,
  input  logic            issue_rs1_ready_i,
  input  rob_idx_t        issue_rs1_tag_i,
  input  logic [XLEN-1:0] issue_rs1_value_i,
  input  logic            issue_rs2_ready_i,
  input  rob_idx_t        issue_rs2_tag_i,
  input  logic [XLEN-1:0] issue_rs2_value_i,
  input  rob_idx_t        issue_rob_idx_i,
  // cdb snoop
  input  logic            cdb_valid_i,
  input  rob_idx_t        cdb_rob_idx_i,
  input  logic [XLEN-1:0] cdb_value_i,
  // result toward the arbiter
  output logic            res_valid_o,
  input  logic            res_ready_i,
  output rob_idx_t        res_rob_idx_o,
  output logic [XLEN-1:0] res_value_o
);

  logic            ex_valid;
  logic            ex_ready;
  alu_op_t         ex_op;
  logic [XLEN-1:0] ex_a;
  logic [XLEN-1:0] ex_b;
  rob_idx_t        ex_rob_idx;
  logic [XLEN-1:0] alu_res;

  logic            res_valid_q;
  rob_idx_t        res_rob_idx_q;
  logic [XLEN-1:0] res_value_q;

  reservation_station #(
    .DEPTH(DEPTH),
    .CTL_T(alu_op_t)
  ) u_rs (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .flush_i          (flush_i),
    .issue_valid_i    (issue_valid_i),
    .issue_ready_o    (issue_ready_o),
    .issue_ctl_i      (alu_op_t'(issue_op_i)),
    .issue_rs1_ready_i(issue_rs1_ready_i),
    .issue_rs1_tag_i  (issue_rs1_tag_i),
    .issue_rs1_value_i(issue_rs1_value_i),
    .issue_rs2_ready_i(issue_rs2_ready_i),
    .issue_rs2_tag_i  (issue_rs2_tag_i),
    .issue_rs2_value_i(issue_rs2_value_i),
    .issue_rob_idx_i  (issue_rob_idx_i),
    .cdb_valid_i      (cdb_valid_i),
    .cdb_rob_idx_i    (cdb_rob_idx_i),
    .cdb_value_i      (cdb_value_i),
    .exec_valid_o     (ex_valid),
    .exec_ready_i     (ex_ready),
    .exec_ctl_o       (ex_op),
    .exec_rs1_value_o (ex_a),
    .exec_rs2_value_o (ex_b),
    .exec_rob_idx_o   (ex_rob_idx)
  );

  // ------------------------------------------------------------------------
  // combinational alu
  // ------------------------------------------------------------------------

  always_comb begin
    unique case (ex_op)
      ALU_ADD: alu_res = ex_a + ex_b;
      ALU_SUB: alu_res = ex_a - ex_b;
      ALU_AND: alu_res = ex_a & ex_b;
      ALU_OR:  alu_res = ex_a | ex_b;
      ALU_XOR: alu_res = ex_a ^ ex_b;
      ALU_SLL: alu_res = ex_a << ex_b[4:0];
      ALU_SRL: alu_res = ex_a >> ex_b[4:0];
      ALU_SLT: alu_res = {{(XLEN-1){1'b0}}, $signed(ex_a) < $signed(ex_b)};
      default: alu_res = '0;
    endcase
  end

  // ------------------------------------------------------------------------
  // result register
  // ------------------------------------------------------------------------

  // refill allowed in the grant cycle
  assign ex_ready = !res_valid_q || res_ready_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i || flush_i) begin
      res_valid_q <= 1'b0;
    end else if (ex_valid && ex_ready) begin
      res_valid_q <= 1'b1;
    end else if (res_ready_i) begin
      res_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ex_valid && ex_ready) begin
      res_rob_idx_q <= ex_rob_idx;
      res_value_q   <= alu_res;
    end
  end

  assign res_valid_o   = res_valid_q;
  assign res_rob_idx_o = res_rob_idx_q;
  assign res_value_o   = res_value_q;

endmodule

/* design/mult_unit.sv */
`timescale 1ns/1ps

module mult_unit import expipe_pkg::*; #(
  parameter int unsigned DEPTH = 2
) (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic            flush_i,
  // issue
  input  logic            issue_valid_i,
  output logic            issue_ready_o,
  input  logic [2:0]      issue_op_i,
  input  logic            issue_rs1_ready_i,
  input  rob_idx_t        issue_rs1_tag_i,
  input  logic [XLEN-1:0] issue_rs1_value_i,
  input  logic            issue_rs2_ready_i,
  input  rob_idx_t        issue_rs2_tag_i,
  input  logic [XLEN-1:0] issue_rs2_value_i,
  input  rob_idx_t        issue_rob_idx_i,
  // cdb snoop
  input  logic            cdb_valid_i,
  input  rob_idx_t        cdb_rob_idx_i,
  input  logic [XLEN-1:0] cdb_value_i,
  // result toward the arbiter
  output logic            res_valid_o,
  input  logic            res_ready_i,
  output rob_idx_t        res_rob_idx_o,
  output logic [XLEN-1:0] res_value_o
);

  logic              ex_valid;
  logic              ex_ready;
  mult_op_t          ex_op;
  logic [XLEN-1:0]   ex_a;
  logic [XLEN-1:0]   ex_b;
  rob_idx_t          ex_rob_idx;

  // stage one, operands
  logic              s1_valid_q;
  mult_op_t          s1_op_q;
  logic [XLEN-1:0]   s1_a_q;
  logic [XLEN-1:0]   s1_b_q;
  rob_idx_t          s1_rob_idx_q;
  logic [2*XLEN-1:0] s1_prod;

  // stage two, full product
  logic              s2_valid_q;
  mult_op_t          s2_op_q;
  rob_idx_t          s2_rob_idx_q;
  logic [2*XLEN-1:0] s2_prod_q;

  logic              s1_adv;
  logic              s2_adv;

  reservation_station #(
    .DEPTH(DEPTH),
    .CTL_T(mult_op_t)
  ) u_rs (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .flush_i          (flush_i),
    .issue_valid_i    (issue_valid_i),
    .issue_ready_o    (issue_ready_o),
    .issue_ctl_i      (mult_op_t'(issue_op_i[0])),
    .issue_rs1_ready_i(issue_rs1_ready_i),
    .issue_rs1_tag_i  (issue_rs1_tag_i),
    .issue_rs1_value_i(issue_rs1_value_i),
    .issue_rs2_ready_i(issue_rs2_ready_i),
    .issue_rs2_tag_i  (issue_rs2_tag_i),
    .issue_rs2_value_i(issue_rs2_value_i),
    .issue_rob_idx_i  (issue_rob_idx_i),
    .cdb_valid_i      (cdb_valid_i),
    .cdb_rob_idx_i    (cdb_rob_idx_i),
    .cdb_value_i      (cdb_value_i),
    .exec_valid_o     (ex_valid),
    .exec_ready_i     (ex_ready),
    .exec_ctl_o       (ex_op),
    .exec_rs1_value_o (ex_a),
    .exec_rs2_value_o (ex_b),
    .exec_rob_idx_o   (ex_rob_idx)
  );

  // ------------------------------------------------------------------------
  // pipeline control
  // ------------------------------------------------------------------------

  // a stage moves when the next one is empty or moving
  assign s2_adv   = !s2_valid_q || res_ready_i;
  assign s1_adv   = !s1_valid_q || s2_adv;
  assign ex_ready = s1_adv;

  assign s1_prod = {{XLEN{1'b0}}, s1_a_q} * {{XLEN{1'b0}}, s1_b_q};

  always_ff @(posedge clk_i) begin
    if (!rst_n_i || flush_i) begin
      s1_valid_q <= 1'b0;
      s2_valid_q <= 1'b0;
    end else begin
      if (s1_adv) s1_valid_q <= ex_valid;
      if (s2_adv) s2_valid_q <= s1_valid_q;
    end
  end

  // payload, frozen under back-pressure
  always_ff @(posedge clk_i) begin
    if (s1_adv) begin
      s1_op_q      <= ex_op;
      s1_a_q       <= ex_a;
      s1_b_q       <= ex_b;
      s1_rob_idx_q <= ex_rob_idx;
    end
    if (s2_adv) begin
      s2_op_q      <= s1_op_q;
      s2_rob_idx_q <= s1_rob_idx_q;
      s2_prod_q    <= s1_prod;
    end
  end

  // half select
  assign res_valid_o   = s2_valid_q;
  assign res_rob_idx_o = s2_rob_idx_q;
  assign res_value_o   = (s2_op_q == MULT_MULHU) ? s2_prod_q[2*XLEN-1:XLEN]
                                                 : s2_prod_q[XLEN-1:0];

endmodule

/* design/cdb_arbiter.sv */
`timescale 1ns/1ps

module cdb_arbiter import expipe_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic            flush_i,
  // requests from the units
  input  logic [EU_N-1:0] req_valid_i,
  input  rob_idx_t        alu_rob_idx_i,
  input  logic [XLEN-1:0] alu_value_i,
  input  rob_idx_t        mult_rob_idx_i,
  input  logic [XLEN-1:0] mult_value_i,
  // one-hot grant, back to the units as ready
  output logic [EU_N-1:0] grant_o,
  // common data bus
  output logic            cdb_valid_o,
  output rob_idx_t        cdb_rob_idx_o,
  output logic [XLEN-1:0] cdb_value_o
);

  // unit that wins a tie
  eu_sel_e prio_q;

  // ------------------------------------------------------------------------
  // grant
  // ------------------------------------------------------------------------

  always_comb begin
    grant_o = req_valid_i;
    if (&req_valid_i) begin
      grant_o         = '0;
      grant_o[prio_q] = 1'b1;
    end
  end

  // the loser of this cycle gets priority next
  always_ff @(posedge clk_i) begin
    if (!rst_n_i || flush_i) begin
      prio_q <= EU_ALU;
    end else if (grant_o[EU_ALU]) begin
      prio_q <= EU_MULT;
    end else if (grant_o[EU_MULT]) begin
      prio_q <= EU_ALU;
    end
  end

  // ------------------------------------------------------------------------
  // bus mux
  // ------------------------------------------------------------------------

  assign cdb_valid_o   = |grant_o;
  assign cdb_rob_idx_o = grant_o[EU_MULT] ? mult_rob_idx_i : alu_rob_idx_i;
  assign cdb_value_o   = grant_o[EU_MULT] ? mult_value_i : alu_value_i;

endmodule

/* design/exec_stage.sv */
`timescale 1ns/1ps

module exec_stage import expipe_pkg::*; #(
  parameter int unsigned ALU_RS_DEPTH  = 4,
  parameter int unsigned MULT_RS_DEPTH = 2
) (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic            flush_i,
  // issue, one valid bit per unit
  input  logic [EU_N-1:0] issue_valid_i,
  output logic [EU_N-1:0] issue_ready_o,
  input  logic [2:0]      issue_op_i,
  input  logic            issue_rs1_ready_i,
  input  rob_idx_t        issue_rs1_tag_i,
  input  logic [XLEN-1:0] issue_rs1_value_i,
  input  logic            issue_rs2_ready_i,
  input  rob_idx_t        issue_rs2_tag_i,
  input  logic [XLEN-1:0] issue_rs2_value_i,
  input  rob_idx_t        issue_rob_idx_i,
  // common data bus toward the rob
  output logic            cdb_valid_o,
  output rob_idx_t        cdb_rob_idx_o,
  output logic [XLEN-1:0] cdb_value_o
);

  // unit results and grants
  logic [EU_N-1:0] res_valid;
  logic [EU_N-1:0] cdb_grant;
  rob_idx_t        alu_rob_idx;
  logic [XLEN-1:0] alu_value;
  rob_idx_t        mult_rob_idx;
  logic [XLEN-1:0] mult_value;

  // ------------------------------------------------------------------------
  // integer alu
  // ------------------------------------------------------------------------

  alu_unit #(
    .DEPTH(ALU_RS_DEPTH)
  ) u_alu_unit (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .flush_i          (flush_i),
    .issue_valid_i    (issue_valid_i[EU_ALU]),
    .issue_ready_o    (issue_ready_o[EU_ALU]),
    .issue_op_i       (issue_op_i),
    .issue_rs1_ready_i(issue_rs1_ready_i),
    .issue_rs1_tag_i  (issue_rs1_tag_i),
    .issue_rs1_value_i(issue_rs1_value_i),
    .issue_rs2_ready_i(issue_rs2_ready_i),
    .issue_rs2_tag_i  (issue_rs2_tag_i),
    .issue_rs2_value_i(issue_rs2_value_i),
    .issue_rob_idx_i  (issue_rob_idx_i),
    .cdb_valid_i      (cdb_valid_o),
    .cdb_rob_idx_i    (cdb_rob_idx_o),
    .cdb_value_i      (cdb_value_o),
    .res_valid_o      (res_valid[EU_ALU]),
    .res_ready_i      (cdb_grant[EU_ALU]),
    .res_rob_idx_o    (alu_rob_idx),
    .res_value_o      (alu_value)
  );

  // ------------------------------------------------------------------------
  // pipelined multiplier
  // ------------------------------------------------------------------------

  mult_unit #(
    .DEPTH(MULT_RS_DEPTH)
  ) u_mult_unit (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .flush_i          (flush_i),
    .issue_valid_i    (issue_valid_i[EU_MULT]),
    .issue_ready_o    (issue_ready_o[EU_MULT]),
    .issue_op_i       (issue_op_i),
    .issue_rs1_ready_i(issue_rs1_ready_i),
    .issue_rs1_tag_i  (issue_rs1_tag_i),
    .issue_rs1_value_i(issue_rs1_value_i),
    .issue_rs2_ready_i(issue_rs2_ready_i),
    .issue_rs2_tag_i  (issue_rs2_tag_i),
    .issue_rs2_value_i(issue_rs2_value_i),
    .issue_rob_idx_i  (issue_rob_idx_i),
    .cdb_valid_i      (cdb_valid_o),
    .cdb_rob_idx_i    (cdb_rob_idx_o),
    .cdb_value_i      (cdb_value_o),
    .res_valid_o      (res_valid[EU_MULT]),
    .res_ready_i      (cdb_grant[EU_MULT]),
    .res_rob_idx_o    (mult_rob_idx),
    .res_value_o      (mult_value)
  );

  // ------------------------------------------------------------------------
  // cdb arbitration, bus also loops back to both stations
  // ------------------------------------------------------------------------

  cdb_arbiter u_cdb_arbiter (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .flush_i       (flush_i),
    .req_valid_i   (res_valid),
    .alu_rob_idx_i (alu_rob_idx),
    .alu_value_i   (alu_value),
    .mult_rob_idx_i(mult_rob_idx),
    .mult_value_i  (mult_value),
    .grant_o       (cdb_grant),
    .cdb_valid_o   (cdb_valid_o),
    .cdb_rob_idx_o (cdb_rob_idx_o),
    .cdb_value_o   (cdb_value_o)
  );

endmodule

/* verification/exec_stage_chk.sv */
`timescale 1ns/1ps

module exec_stage_chk import expipe_pkg::*; (
  input logic            clk_i,
  input logic            rst_n_i,
  input logic            flush_i,
  input logic [EU_N-1:0] req_i,
  input logic [EU_N-1:0] grant_i,
  input logic            cdb_valid_i
);

  // ------------------------------------------------------------------------
  // cdb arbitration
  // ------------------------------------------------------------------------

  // one unit owns the bus at most
  a_grant_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(grant_i))
    else $error("more than one unit granted onto the cdb");

  // bus busy whenever a unit waits, grants only to requesters
  a_valid_is_request: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (cdb_valid_i == |req_i) && ((grant_i & ~req_i) == '0))
    else $error("cdb_valid_o or the grant vector disagrees with the unit requests");

  // ------------------------------------------------------------------------
  // flush
  // ------------------------------------------------------------------------

  // every result register is cleared by the flush edge
  a_flush_quiet: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    flush_i |=> !cdb_valid_i)
    else $error("cdb_valid_o high in the cycle after a flush");

endmodule

bind exec_stage exec_stage_chk u_exec_stage_chk (
  .clk_i      (clk_i),
  .rst_n_i    (rst_n_i),
  .flush_i    (flush_i),
  .req_i      (res_valid),
  .grant_i    (cdb_grant),
  .cdb_valid_i(cdb_valid_o)
);

/* verification/tb_exec_stage.sv */
`timescale 1ns/1ps

module tb_exec_stage import expipe_pkg::*; ();

  localparam int unsigned ALU_DEPTH  = 4;
  localparam int unsigned MULT_DEPTH = 2;
  // entries a unit can hold, station plus result stages
  localparam int ALU_CAP    = ALU_DEPTH + 1;
  localparam int MULT_CAP   = MULT_DEPTH + 2;
  localparam int NTAGS      = 1 << ROB_IDX_LEN;
  localparam int WAIT_LIMIT = 200;

  logic            clk_i;
  logic            rst_n_i;
  logic            flush_i;
  logic [EU_N-1:0] issue_valid_i;
  logic [EU_N-1:0] issue_ready_o;
  logic [2:0]      issue_op_i;
  logic            issue_rs1_ready_i;
  rob_idx_t        issue_rs1_tag_i;
  logic [XLEN-1:0] issue_rs1_value_i;
  logic            issue_rs2_ready_i;
  rob_idx_t        issue_rs2_tag_i;
  logic [XLEN-1:0] issue_rs2_value_i;
  rob_idx_t        issue_rob_idx_i;
  logic            cdb_valid_o;
  rob_idx_t        cdb_rob_idx_o;
  logic [XLEN-1:0] cdb_value_o;

  // stimulus side bookkeeping
  logic [31:0]     lfsr_q = 32'had19_bef4;
  rob_idx_t        next_tag;
  int              issued_n  [NTAGS];
  int              dropped_n [NTAGS];
  logic [XLEN-1:0] exp_val   [NTAGS];
  eu_sel_e         unit_of   [NTAGS];
  // written by the scoreboard only
  int              retired_n [NTAGS];

  exec_stage #(
    .ALU_RS_DEPTH (ALU_DEPTH),
    .MULT_RS_DEPTH(MULT_DEPTH)
  ) dut (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .flush_i          (flush_i),
    .issue_valid_i    (issue_valid_i),
    .issue_ready_o    (issue_ready_o),
    .issue_op_i       (issue_op_i),
    .issue_rs1_ready_i(issue_rs1_ready_i),
    .issue_rs1_tag_i  (issue_rs1_tag_i),
    .issue_rs1_value_i(issue_rs1_value_i),
    .issue_rs2_ready_i(issue_rs2_ready_i),
    .issue_rs2_tag_i  (issue_rs2_tag_i),
    .issue_rs2_value_i(issue_rs2_value_i),
    .issue_rob_idx_i  (issue_rob_idx_i),
    .cdb_valid_o      (cdb_valid_o),
    .cdb_rob_idx_o    (cdb_rob_idx_o),
    .cdb_value_o      (cdb_value_o)
  );

  // 40 ns period
  always #20 clk_i = ~clk_i;

  // ------------------------------------------------------------------------
  // random source and reference model
  // ------------------------------------------------------------------------

  // taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one lfsr step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      r      = {r[30:0], lfsr_q[0]};
    end
    return r;
  endfunction

  function automatic logic [XLEN-1:0] ref_result(input eu_sel_e u, input logic [2:0] op,
                                                 input logic [XLEN-1:0] a,
                                                 input logic [XLEN-1:0] b);
    logic [2*XLEN-1:0] prod;
    prod = (2*XLEN)'(a) * (2*XLEN)'(b);
    // multiplier looks at the low op bit only
    if (u == EU_MULT) return op[0] ? prod[2*XLEN-1:XLEN] : prod[XLEN-1:0];
    case (op)
      ALU_ADD: return a + b;
      ALU_SUB: return a - b;
      ALU_AND: return a & b;
      ALU_OR:  return a | b;
      ALU_XOR: return a ^ b;
      ALU_SLL: return a << b[4:0];
      ALU_SRL: return a >> b[4:0];
      ALU_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      default: return '0;
    endcase
  endfunction

  // ------------------------------------------------------------------------
  // tag tracking
  // ------------------------------------------------------------------------

  function automatic bit is_pending(input int t);
    return issued_n[t] != retired_n[t] + dropped_n[t];
  endfunction

  // outstanding, or being broadcast in this very cycle
  function automatic bit tag_live(input int t);
    return is_pending(t) || (cdb_valid_o && int'(cdb_rob_idx_o) == t);
  endfunction

  function automatic int unit_load(input eu_sel_e u);
    int n;
    n = 0;
    for (int t = 0; t < NTAGS; t++) begin
      if (is_pending(t) && unit_of[t] == u) n++;
    end
    return n;
  endfunction

  // first live tag from a random start, -1 when none
  function automatic int pick_producer(input int start);
    int t;
    for (int i = 0; i < NTAGS; i++) begin
      t = (start + i) % NTAGS;
      if (tag_live(t)) return t;
    end
    return -1;
  endfunction

  // operand either ready with a random value or waiting on a live tag
  function automatic void pick_operand(input bit allow_dep, output logic rdy,
                                       output rob_idx_t tag, output logic [XLEN-1:0] drv,
                                       output logic [XLEN-1:0] val);
    int p;
    p = -1;
    if (allow_dep && rand_bits(1) == 32'd1) p = pick_producer(int'(rand_bits(4)));
    if (p >= 0) begin
      rdy = 1'b0;
      tag = rob_idx_t'(p);
      val = exp_val[p];
      // garbage on the value port, station must wait for the bus
      drv = ~exp_val[p];
    end else begin
      rdy = 1'b1;
      tag = rob_idx_t'(rand_bits(4));
      val = rand_bits(32);
      drv = val;
    end
  endfunction

  // ------------------------------------------------------------------------
  // error handling and checks
  // ------------------------------------------------------------------------

  task stop_run();
    $display("Finished with errors");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task report_error(input string what);
    $display("Error at time %0t: %s", $time, what);
    stop_run();
  endtask

  task check_eq(input string name, input logic [31:0] got, input logic [31:0] expected);
    if (got !== expected) begin
      $display("Mismatch at time %0t: %s is 0x%08h, expected 0x%08h",
               $time, name, got, expected);
      stop_run();
    end
  endtask

  // scoreboard, mid-cycle where the bus is settled
  always @(negedge clk_i) begin
    if (rst_n_i) begin
      if ($isunknown(cdb_valid_o)) begin
        report_error("cdb_valid_o is unknown");
      end else if (cdb_valid_o) begin
        if (!is_pending(int'(cdb_rob_idx_o))) begin
          report_error($sformatf("tag %0d on the cdb is unknown, flushed or repeated",
                                 cdb_rob_idx_o));
        end else begin
          check_eq("cdb_value_o", cdb_value_o, exp_val[cdb_rob_idx_o]);
          retired_n[cdb_rob_idx_o]++;
        end
      end
    end
  end

  // ------------------------------------------------------------------------
  // stimulus tasks, all entered and left on a falling edge
  // ------------------------------------------------------------------------

  task issue_one(input eu_sel_e u, input logic [2:0] op, input bit allow_dep);
    int              cycles;
    int              cap;
    logic [XLEN-1:0] va;
    logic [XLEN-1:0] vb;
    cycles = 0;
    // free station entry and a tag that is not in flight
    while (!(issue_ready_o[u] && !tag_live(int'(next_tag)))) begin
      if (cycles == WAIT_LIMIT) begin
        report_error("timeout waiting for a free station entry and tag");
      end else begin
        cycles++;
        @(negedge clk_i);
      end
    end
    pick_operand(allow_dep, issue_rs1_ready_i, issue_rs1_tag_i, issue_rs1_value_i, va);
    pick_operand(allow_dep, issue_rs2_ready_i, issue_rs2_tag_i, issue_rs2_value_i, vb);
    issue_op_i         = op;
    issue_rob_idx_i    = next_tag;
    issue_valid_i      = '0;
    issue_valid_i[u]   = 1'b1;
    // ready must not outrun station depth plus result stages
    cap = (u == EU_ALU) ? ALU_CAP : MULT_CAP;
    check_eq("issue_ready_o", 32'(unit_load(u) < cap), 32'd1);
    exp_val[next_tag]  = ref_result(u, op, va, vb);
    unit_of[next_tag]  = u;
    issued_n[next_tag]++;
    next_tag++;
    @(negedge clk_i);
    issue_valid_i = '0;
  endtask

  task random_traffic(input int n);
    eu_sel_e u;
    for (int i = 0; i < n; i++) begin
      // about one idle cycle in four
      if (rand_bits(2) == 32'd0) @(negedge clk_i);
      u = (rand_bits(1) == 32'd1) ? EU_MULT : EU_ALU;
      issue_one(u, 3'(rand_bits(3)), 1'b1);
    end
  endtask

  task flush_all();
    // an issue under flush is dropped too
    issue_op_i        = ALU_ADD;
    issue_rs1_ready_i = 1'b1;
    issue_rs2_ready_i = 1'b1;
    issue_rob_idx_i   = next_tag;
    issue_valid_i     = '0;
    issue_valid_i[EU_ALU] = 1'b1;
    flush_i = 1'b1;
    @(negedge clk_i);
    flush_i       = 1'b0;
    issue_valid_i = '0;
    // bus is quiet now, so nothing retires in this step
    for (int t = 0; t < NTAGS; t++) begin
      dropped_n[t] = issued_n[t] - retired_n[t];
    end
    // skip the tag of the dropped issue
    next_tag++;
  endtask

  task drain();
    int cycles;
    cycles = 0;
    while (unit_load(EU_ALU) + unit_load(EU_MULT) != 0) begin
      if (cycles == WAIT_LIMIT) begin
        report_error("timeout, issued tags never appeared on the cdb");
      end else begin
        cycles++;
        @(negedge clk_i);
      end
    end
  endtask

  // ------------------------------------------------------------------------
  // test sequence
  // ------------------------------------------------------------------------

  initial begin
    clk_i             = 1'b0;
    rst_n_i           = 1'b0;
    flush_i           = 1'b0;
    issue_valid_i     = '0;
    issue_op_i        = '0;
    issue_rs1_ready_i = 1'b0;
    issue_rs1_tag_i   = '0;
    issue_rs1_value_i = '0;
    issue_rs2_ready_i = 1'b0;
    issue_rs2_tag_i   = '0;
    issue_rs2_value_i = '0;
    issue_rob_idx_i   = '0;
    next_tag          = '0;
    repeat (16) @(negedge clk_i);
    rst_n_i = 1'b1;

    // empty stations, quiet bus
    check_eq("issue_ready_o", 32'(issue_ready_o), 32'h3);
    repeat (4) begin
      @(negedge clk_i);
      check_eq("cdb_valid_o", 32'(cdb_valid_o), 32'd0);
    end

    // each alu op once, independent operands
    for (int op = 0; op < 8; op++) issue_one(EU_ALU, 3'(op), 1'b0);
    drain();

    // back to back mul and mulhu keep both stages busy
    for (int i = 0; i < 8; i++) issue_one(EU_MULT, 3'(i), 1'b0);
    drain();

    // mixed traffic, chains across both units
    random_traffic(80);
    drain();

    // flush with work in flight, then recover
    random_traffic(6);
    flush_all();
    random_traffic(30);
    drain();

    $display("Finished with no errors");
    $finish;
  end

endmodule

/* project.f */
design/expipe_pkg.sv
design/reservation_station.sv
design/alu_unit.sv
design/mult_unit.sv
design/cdb_arbiter.sv
design/exec_stage.sv
verification/exec_stage_chk.sv
verification/tb_exec_stage.sv

/* Makefile */
# Verilator build and run of the execution stage testbench

VERILATOR  ?= verilator
TOP        ?= tb_exec_stage
FILELIST   ?= project.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
FAIL_MSG   ?= Finished with errors
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)

# fails on a nonzero exit status or on the fail message in the log
run: build
	@./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
